// File: verilog/rs232_pkg.sv
/*
  rs232 transmit device, shared definitions
  widths, register select, transmitter states and status bit positions
*/

`default_nettype none

package rs232_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int data_width = 8;   // one character
  localparam int bus_width  = 32;  // processor bus word

  // ------------------------------
  // register select, word address
  // ------------------------------
  typedef enum logic {
    reg_data = 1'b0,  // tx data, reads back zero
    reg_ctrl = 1'b1   // status on read
  } rs232_reg_t;

  // ------------------------------
  // serializer states
  // ------------------------------
  typedef enum logic [1:0] {
    tx_idle  = 2'd0,
    tx_start = 2'd1,
    tx_data  = 2'd2,
    tx_stop  = 2'd3
  } tx_state_t;

  // status word bit positions
  localparam int stat_busy_bit = 0;  // buffer non-empty or frame on the line
  localparam int stat_rdy_bit  = 1;  // room for another byte

endpackage

`default_nettype wire

// File: verilog/rs232_regs.sv
/*
  rs232 bus slave: data and status registers
  pushes written bytes into the tx buffer, acks every access one cycle later
*/

`timescale 1ns/1ps
`default_nettype none

module rs232_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  // processor bus
  input  logic                             stb,
  input  logic                             we,
  input  rs232_pkg::rs232_reg_t            addr,
  input  logic [rs232_pkg::bus_width-1:0]  data_in,
  output logic [rs232_pkg::bus_width-1:0]  data_out,
  output logic                             ack,
  // buffer side
  input  logic                             fifo_full,
  input  logic                             fifo_empty,
  input  logic                             tx_active,
  output logic                             push,
  output logic [rs232_pkg::data_width-1:0] push_data
);

  import rs232_pkg::*;

  logic                 wr_data;  // write to the data register
  logic [bus_width-1:0] status;   // assembled status word
  logic [bus_width-1:0] rd_word;  // read mux result

  // ------------------------------
  // write side
  // ------------------------------

  // ctrl writes fall through, nothing to configure
  assign wr_data = stb & we & (addr == reg_data);

  // full buffer -> byte dropped, software polls rdy first
  assign push      = wr_data & ~fifo_full;
  assign push_data = data_in[data_width-1:0];  // low byte only

  // ------------------------------
  // read side
  // ------------------------------

  always_comb begin
    status                = '0;
    status[stat_rdy_bit]  = ~fifo_full;                // room left
    status[stat_busy_bit] = ~fifo_empty | tx_active;   // queued or sending
  end

  always_comb begin
    case (addr)
      reg_ctrl: rd_word = status;
      default:  rd_word = '0;   // no receive path
    endcase
  end

  // one-cycle ack, read data only while ack is up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack      <= 1'b0;
      data_out <= '0;
    end else begin
      ack      <= stb;
      data_out <= (stb & ~we) ? rd_word : '0;  // flags as seen at the stb edge
    end
  end

endmodule

`default_nettype wire

// File: verilog/tx_fifo.sv
/*
  tx byte buffer, show-ahead circular FIFO of buf_slots entries
  any depth of 2 or more, head entry always visible on pop_data
*/

`timescale 1ns/1ps
`default_nettype none

module tx_fifo #(
  parameter int buf_slots = 255
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             push,
  input  logic [rs232_pkg::data_width-1:0] push_data,
  input  logic                             pop,
  output logic [rs232_pkg::data_width-1:0] pop_data,
  output logic                             fifo_empty,
  output logic                             fifo_full
);

  import rs232_pkg::*;

  localparam int ptr_w = $clog2(buf_slots);
  localparam int cnt_w = $clog2(buf_slots + 1);

  logic [data_width-1:0] mem [buf_slots];  // storage
  logic [ptr_w-1:0]      rd_ptr;           // oldest entry
  logic [ptr_w-1:0]      wr_ptr;           // next free slot
  logic [cnt_w-1:0]      count;            // occupancy
  logic                  do_push;
  logic                  do_pop;

  assign do_push = push & ~fifo_full;   // guard, regs never push when full
  assign do_pop  = pop & ~fifo_empty;

  // ------------------------------
  // pointers and count
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)  // wrap by compare, depth need not be a power of two
        wr_ptr <= (wr_ptr == ptr_w'(buf_slots - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_w'(buf_slots - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
      // push and pop together, count holds
    end
  end

  // storage write
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  assign pop_data   = mem[rd_ptr];               // show-ahead head
  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == cnt_w'(buf_slots));

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
/*
  rs232 transmitter, baud divider and 8N1 frame serializer
  pulls the next byte from the buffer whenever a frame is done
*/

`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int clock_freq = 50_000_000,
  parameter int baud_rate  = 115_200
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             fifo_empty,
  input  logic [rs232_pkg::data_width-1:0] pop_data,
  output logic                             pop,
  output logic                             txd,
  output logic                             tx_active
);

  import rs232_pkg::*;

  localparam int bit_cycles = clock_freq / baud_rate;
  localparam int cnt_w      = (bit_cycles > 1) ? $clog2(bit_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_top = cnt_w'(bit_cycles - 1);

  tx_state_t             state;
  logic [cnt_w-1:0]      baud_cnt;  // cycles left in current bit
  logic [2:0]            bit_idx;   // data bit being sent
  logic [data_width-1:0] shift;     // remaining data bits, lsb out
  logic                  bit_end;   // last cycle of a bit period

  assign bit_end   = (baud_cnt == '0);
  assign tx_active = (state != tx_idle);

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= tx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      txd      <= 1'b1;   // line idles high
      pop      <= 1'b0;
    end else begin
      // arm pop when idle, or early at the stop bit end -> one cycle gap
      pop <= ~fifo_empty & ((state == tx_idle & ~pop) | (state == tx_stop & bit_end));
      baud_cnt <= bit_end ? cnt_top : baud_cnt - 1'b1;
      case (state)
        tx_idle: begin
          baud_cnt <= cnt_top;
          if (pop) begin       // byte taken at this edge
            txd   <= 1'b0;     // start bit
            state <= tx_start;
          end
        end
        tx_start: if (bit_end) begin
          txd     <= shift[0];
          bit_idx <= '0;
          state   <= tx_data;
        end
        tx_data: if (bit_end) begin
          if (bit_idx == 3'(data_width - 1)) begin
            txd   <= 1'b1;     // stop bit
            state <= tx_stop;
          end else begin
            txd     <= shift[0];
            bit_idx <= bit_idx + 1'b1;
          end
        end
        tx_stop: if (bit_end) state <= tx_idle;
        default: state <= tx_idle;
      endcase
    end
  end

  // ------------------------------
  // data shifter
  // ------------------------------
  always_ff @(posedge clk) begin
    if (state == tx_idle && pop)
      shift <= pop_data;                    // latch head of buffer
    else if ((state == tx_start || state == tx_data) && bit_end)
      shift <= shift >> 1;                  // next bit into lsb
  end

endmodule

`default_nettype wire

// File: verilog/rs232_io.sv
/*
  buffered rs232 transmit device, one slave on the processor bus
  register block -> tx FIFO -> serializer
*/

`timescale 1ns/1ps
`default_nettype none

module rs232_io #(
  parameter int clock_freq = 50_000_000,
  parameter int baud_rate  = 115_200,
  parameter int buf_slots  = 255
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            stb,
  input  logic                            we,
  input  rs232_pkg::rs232_reg_t           addr,     // data/status select
  input  logic [rs232_pkg::bus_width-1:0] data_in,
  output logic [rs232_pkg::bus_width-1:0] data_out,
  output logic                            ack,
  output logic                            txd       // serial out
);

  import rs232_pkg::*;

  logic                  push;       // regs -> fifo
  logic [data_width-1:0] push_data;
  logic                  pop;        // tx -> fifo
  logic [data_width-1:0] pop_data;
  logic                  fifo_empty;
  logic                  fifo_full;
  logic                  tx_active;  // frame in progress

  rs232_regs regs_0 (
    .clk(clk), .rst_n(rst_n),
    .stb(stb), .we(we), .addr(addr),
    .data_in(data_in), .data_out(data_out), .ack(ack),
    .fifo_full(fifo_full), .fifo_empty(fifo_empty), .tx_active(tx_active),
    .push(push), .push_data(push_data)
  );

  tx_fifo #(.buf_slots(buf_slots)) fifo_0 (
    .clk(clk), .rst_n(rst_n),
    .push(push), .push_data(push_data),
    .pop(pop), .pop_data(pop_data),
    .fifo_empty(fifo_empty), .fifo_full(fifo_full)
  );

  uart_tx #(.clock_freq(clock_freq), .baud_rate(baud_rate)) tx_0 (
    .clk(clk), .rst_n(rst_n),
    .fifo_empty(fifo_empty), .pop_data(pop_data),
    .pop(pop), .txd(txd), .tx_active(tx_active)
  );

endmodule

`default_nettype wire

// File: bench/tb_rs232_io.sv
/*
  testbench for the buffered rs232 transmit device
  bus driver, serial line decoder, reference status model and byte checks
*/

`timescale 1ns/1ps
`default_nettype none

module tb_rs232_io;

  import rs232_pkg::*;

  localparam int clk_period  = 8;
  localparam int clock_freq  = 800;
  localparam int baud_rate   = 100;
  localparam int buf_slots   = 8;
  localparam int bit_cycles  = clock_freq / baud_rate;   // 8 cycles per bit
  localparam int total_bytes = 19;                       // 1 + 6 + 12 attempts
  localparam int cycle_limit = (total_bytes * 10 * bit_cycles * 3) / 2 + 500;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic                 stb;
  logic                 we;
  rs232_reg_t           addr;
  logic [bus_width-1:0] data_in;
  logic [bus_width-1:0] data_out;
  logic                 ack;
  logic                 txd;

  logic [data_width-1:0] exp_q[$];   // accepted writes in order
  logic [data_width-1:0] rx_q[$];    // bytes decoded off txd
  logic [31:0]           rng = 32'hacdb_132e;
  time                   last_drive_time;
  time                   last_start_time;
  int                    cycles = 0;
  int                    errors = 0;
  int                    n_checks = 0;
  int                    n_tests = 0;
  int                    err_mark = 0;
  int                    rx_count = 0;

  rs232_io #(
    .clock_freq(clock_freq),
    .baud_rate(baud_rate),
    .buf_slots(buf_slots)
  ) dut (
    .clk(clk), .rst_n(rst_n),
    .stb(stb), .we(we), .addr(addr),
    .data_in(data_in), .data_out(data_out), .ack(ack),
    .txd(txd)
  );

  always #(clk_period / 2) clk = ~clk;

  // watchdog sized from the frame count
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles with %0d frames still outstanding",
               cycles, exp_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // status word as software should see it
  function automatic logic [31:0] expected_status(input int pending, input logic active);
    logic [31:0] s;
    s                = '0;
    s[stat_rdy_bit]  = (pending < buf_slots);
    s[stat_busy_bit] = (pending > 0) || active;
    return s;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] want,
                          input string what);
    n_checks++;
    if (got !== want) begin
      $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  // one bus cycle with stb held one clock and data captured on ack
  task automatic bus_access(input logic write, input rs232_reg_t sel,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int latency);
    int n;
    @(posedge clk);
    last_drive_time = $time;
    stb     <= 1'b1;
    we      <= write;
    addr    <= sel;
    data_in <= wdata;
    @(posedge clk);
    stb <= 1'b0;
    we  <= 1'b0;
    n = 1;
    @(negedge clk);
    while (!ack && n < 4) begin   // give up after a few clocks
      n++;
      @(negedge clk);
    end
    if (!ack) begin
      $display("no ack from the DUT for a bus access at %0t ns", $time);
      errors++;
    end
    latency = n;
    rdata   = data_out;
  endtask

  task automatic read_status(output logic [31:0] st);
    int lat;
    bus_access(1'b0, reg_ctrl, 32'h0, st, lat);
  endtask

  task automatic send_word(input logic [31:0] w);
    logic [31:0] q;
    int          lat;
    bus_access(1'b1, reg_data, w, q, lat);
    exp_q.push_back(w[data_width-1:0]);   // only the low byte goes out
  endtask

  task automatic wait_frames_done();
    while (exp_q.size() != 0 || rx_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic wait_not_busy();
    logic [31:0] st;
    read_status(st);
    while (st[stat_busy_bit])
      read_status(st);
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s %s (%0d errors)", n_tests + 1, name,
             (errors == err_mark) ? "ok" : "FAILED", errors - err_mark);
    err_mark = errors;
    n_tests++;
  endtask

  // ------------------------------
  // serial line decoder
  // ------------------------------
  initial begin : line_decoder
    logic [data_width-1:0] b;
    @(posedge rst_n);
    forever begin
      @(negedge txd);
      last_start_time = $time;
      repeat (bit_cycles / 2) @(negedge clk);   // mid start bit
      check_eq(txd, 0, "start bit");
      for (int i = 0; i < data_width; i++) begin
        repeat (bit_cycles) @(negedge clk);
        b[i] = txd;                              // lsb first
      end
      repeat (bit_cycles) @(negedge clk);
      check_eq(txd, 1, "stop bit");
      rx_q.push_back(b);
      rx_count++;
    end
  end

  // received bytes against the accepted writes
  initial begin : compare_bytes
    logic [data_width-1:0] got;
    forever begin
      @(posedge clk);
      while (rx_q.size() > 0) begin
        got = rx_q.pop_front();
        if (exp_q.size() == 0) begin
          $display("byte %h appeared on txd at %0t ns but none was expected", got, $time);
          errors++;
        end else
          check_eq(got, exp_q.pop_front(), "received byte");
      end
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin : main
    logic [31:0] q;
    logic [31:0] w;
    int          lat;
    int          n_acc;
    int          n_drop;
    int          rx_before;
    time         t_wr;
    stb     <= 1'b0;
    we      <= 1'b0;
    addr    <= reg_data;
    data_in <= '0;
    rst_n   <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // reset state, ack timing, zero reads
    check_eq(txd, 1, "txd idle after reset");
    bus_access(1'b0, reg_ctrl, 32'h0, q, lat);
    check_eq(q, expected_status(0, 1'b0), "status after reset");
    check_eq(lat, 1, "ack latency");
    @(negedge clk);
    check_eq(ack, 0, "ack longer than one cycle");
    bus_access(1'b0, reg_data, 32'hffff_ffff, q, lat);
    check_eq(q, 0, "data register read");
    bus_access(1'b1, reg_ctrl, 32'h0000_00ff, q, lat);   // ignored
    read_status(q);
    check_eq(q, expected_status(0, 1'b0), "status after ctrl write");
    end_test("reset");

    // one frame with the start bit 3 cycles after the write
    w = next_rand();
    send_word(w);
    t_wr = last_drive_time;
    read_status(q);   // sampled just before the first pop
    check_eq(q, expected_status(1, 1'b0), "status with one byte queued");
    wait_frames_done();
    read_status(q);   // buffer empty, stop bit still on the line
    check_eq(q, expected_status(0, 1'b1), "status during the stop bit");
    check_eq((last_start_time - t_wr) / clk_period, 3, "start bit delay");
    end_test("single");

    repeat (6) send_word(next_rand());
    wait_frames_done();
    end_test("burst");

    // overrun with a poll before every write
    wait_not_busy();
    n_acc  = 0;
    n_drop = 0;
    repeat (12) begin
      read_status(q);
      w = next_rand();
      if (q[stat_rdy_bit]) begin
        send_word(w);
        n_acc++;
      end else begin
        check_eq(q, expected_status(buf_slots, 1'b1), "status with the buffer full");
        bus_access(1'b1, reg_data, w, q, lat);   // expected to be lost
        n_drop++;
      end
    end
    check_eq(n_drop > 0, 1, "buffer never reported full");
    wait_frames_done();
    end_test("full");

    // drain back to idle while the line stays quiet
    wait_not_busy();
    read_status(q);
    check_eq(q, expected_status(0, 1'b0), "status after drain");
    rx_before = rx_count;
    repeat (2 * 10 * bit_cycles) @(negedge clk);
    check_eq(txd, 1, "txd idle after drain");
    check_eq(rx_count, rx_before, "frames after drain");
    check_eq(rx_count, 7 + n_acc, "total frames");
    end_test("drain");

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
verilog/rs232_pkg.sv
verilog/rs232_regs.sv
verilog/tx_fifo.sv
verilog/uart_tx.sv
verilog/rs232_io.sv
bench/tb_rs232_io.sv

// File: Makefile
# Verilator build and run of the rs232 transmit device testbench
TOP = tb_rs232_io

.PHONY: build run clean

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f

# pass only when the pass line shows up in the output
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
